/* design/mul_data_pkg.sv */
// Operand, product and register-tag widths for the RV32M multiply unit.
// Every design file refers to these types by scoped name.
package mul_data_pkg;

    // Operand and result word width fixed by RV32.
    localparam int XLEN = 32;

    // Integer register file has 32 entries.
    localparam int RD_W = 5;

    // One operand or one result word.
    typedef logic [XLEN-1:0] xlen_t;

    // Full unsigned product of two words.
    typedef logic [2*XLEN-1:0] prod_t;

    // Destination register number carried alongside each request.
    typedef logic [RD_W-1:0] rd_t;

endpackage

/* design/mul_op_pkg.sv */
// Multiply operation codes and the control and data structs that move
// between the decode, execute and result stages.
package mul_op_pkg;

    // Low two bits of funct3 for the multiply group.
    typedef logic [1:0] funct_t;

    localparam funct_t FN_MUL    = 2'd0;
    localparam funct_t FN_MULH   = 2'd1;
    localparam funct_t FN_MULHSU = 2'd2;
    localparam funct_t FN_MULHU  = 2'd3;

    // Control that rides with every request down the whole pipeline.
    typedef struct packed {
        logic              valid;
        mul_data_pkg::rd_t rd;
        // The true product is the negative of the magnitude product.
        logic              negate;
        logic              take_high;
    } mul_ctrl_t;

    // Decode to execute.
    typedef struct packed {
        mul_ctrl_t           ctrl;
        mul_data_pkg::xlen_t mag_a;
        mul_data_pkg::xlen_t mag_b;
    } dec_out_t;

    // Execute to result.
    typedef struct packed {
        mul_ctrl_t           ctrl;
        mul_data_pkg::prod_t prod;
    } exe_out_t;

endpackage

/* design/hc_adder.sv */
// Han-Carlson parallel-prefix adder over a full product width.
// Used in the partial-product tree and for product negation.
`timescale 1ns/1ps

module hc_adder (
    input  mul_data_pkg::prod_t a,
    input  mul_data_pkg::prod_t b,
    input  logic                cin,
    output mul_data_pkg::prod_t sum,
    output logic                cout
);

    localparam int W      = $bits(mul_data_pkg::prod_t);
    localparam int LEVELS = $clog2(W);

    logic [W-1:0] g;
    logic [W-1:0] p;
    logic [W-1:0] g_lv [0:LEVELS];
    logic [W-1:0] p_lv [0:LEVELS];
    logic [W-1:0] carry;

    assign g = a & b;
    assign p = a ^ b;

    always_comb begin
        int span;

        // Carry in is folded into the generate of bit zero.
        g_lv[0]    = g;
        g_lv[0][0] = g[0] | (p[0] & cin);
        p_lv[0]    = p;

        // Each odd bit first absorbs the even bit just below it.
        g_lv[1] = g_lv[0];
        p_lv[1] = p_lv[0];
        for (int i = 1; i < W; i += 2) begin
            g_lv[1][i] = g_lv[0][i] | (p_lv[0][i] & g_lv[0][i-1]);
            p_lv[1][i] = p_lv[0][i] & p_lv[0][i-1];
        end

        // Kogge-Stone over the odd positions, doubling the span each level.
        for (int lv = 2; lv <= LEVELS; lv++) begin
            span    = 1 << (lv - 1);
            g_lv[lv] = g_lv[lv-1];
            p_lv[lv] = p_lv[lv-1];
            for (int i = 1; i < W; i += 2) begin
                if (i >= span) begin
                    g_lv[lv][i] = g_lv[lv-1][i] | (p_lv[lv-1][i] & g_lv[lv-1][i-span]);
                    p_lv[lv][i] = p_lv[lv-1][i] & p_lv[lv-1][i-span];
                end
            end
        end

        // Even positions pick up the finished carry from their odd neighbour.
        carry[0] = g_lv[LEVELS][0];
        for (int i = 1; i < W; i++) begin
            if (i % 2 == 1) begin
                carry[i] = g_lv[LEVELS][i];
            end else begin
                carry[i] = g_lv[LEVELS][i] | (p_lv[LEVELS][i] & g_lv[LEVELS][i-1]);
            end
        end
    end

    // carry[i] is the carry out of bit i.
    assign sum  = p ^ {carry[W-2:0], cin};
    assign cout = carry[W-1];

endmodule

/* design/mul_decode.sv */
// Decode stage of the multiply pipeline. Reads funct, converts signed
// operands to magnitudes and registers them with the request control.
`timescale 1ns/1ps

module mul_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  mul_op_pkg::funct_t   funct,
    input  mul_data_pkg::xlen_t  rs1,
    input  mul_data_pkg::xlen_t  rs2,
    input  mul_data_pkg::rd_t    rd,
    output mul_op_pkg::dec_out_t dec
);

    localparam int MSB = $bits(mul_data_pkg::xlen_t) - 1;

    logic                a_signed;
    logic                b_signed;
    logic                a_neg;
    logic                b_neg;
    mul_data_pkg::xlen_t mag_a;
    mul_data_pkg::xlen_t mag_b;

    // rs1 is signed for MULH and MULHSU, rs2 only for MULH.
    assign a_signed = (funct == mul_op_pkg::FN_MULH) || (funct == mul_op_pkg::FN_MULHSU);
    assign b_signed = (funct == mul_op_pkg::FN_MULH);

    assign a_neg = a_signed & rs1[MSB];
    assign b_neg = b_signed & rs2[MSB];

    // The two's complement of the most negative value reads correctly as unsigned.
    assign mag_a = a_neg ? (~rs1 + 1'b1) : rs1;
    assign mag_b = b_neg ? (~rs2 + 1'b1) : rs2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec <= '0;
        end else begin
            dec.ctrl.valid     <= start;
            dec.ctrl.rd        <= rd;
            dec.ctrl.negate    <= a_neg ^ b_neg;
            dec.ctrl.take_high <= (funct != mul_op_pkg::FN_MUL);
            dec.mag_a          <= mag_a;
            dec.mag_b          <= mag_b;
        end
    end

endmodule

/* design/mul_execute.sv */
// Execute stage of the multiply pipeline. Forms the unsigned product of the
// two magnitudes through a five-level Han-Carlson adder tree.
`timescale 1ns/1ps

module mul_execute (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mul_op_pkg::dec_out_t dec,
    output mul_op_pkg::exe_out_t exe
);

    localparam int N      = $bits(mul_data_pkg::xlen_t);
    localparam int LEVELS = $clog2(N);
    localparam int NODES  = 2 * N - 1;

    // Nodes 0 to N-1 hold partial products and the adder outputs follow level
    // by level, so the last node is the full product.
    mul_data_pkg::prod_t node [0:NODES-1];

    genvar i;
    genvar lv;
    genvar k;

    generate
        for (i = 0; i < N; i++) begin : g_pp
            assign node[i] = dec.mag_a[i] ? (mul_data_pkg::prod_t'(dec.mag_b) << i) : '0;
        end

        for (lv = 1; lv <= LEVELS; lv++) begin : g_level
            localparam int IN_BASE  = 2 * N - ((2 * N) >> (lv - 1));
            localparam int OUT_BASE = 2 * N - ((2 * N) >> lv);
            localparam int COUNT    = N >> lv;

            for (k = 0; k < COUNT; k++) begin : g_add
                hc_adder u_add (
                    .a    (node[IN_BASE + 2*k]),
                    .b    (node[IN_BASE + 2*k + 1]),
                    .cin  (1'b0),
                    .sum  (node[OUT_BASE + k]),
                    .cout ()
                );
            end
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exe <= '0;
        end else begin
            exe.ctrl <= dec.ctrl;
            exe.prod <= node[NODES-1];
        end
    end

endmodule

/* design/mul_result.sv */
// Result stage of the multiply pipeline. Restores the sign of the product,
// picks the requested word and registers the outputs.
`timescale 1ns/1ps

module mul_result (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mul_op_pkg::exe_out_t exe,
    output logic                 done,
    output mul_data_pkg::xlen_t  result,
    output mul_data_pkg::rd_t    result_rd
);

    localparam int N = $bits(mul_data_pkg::xlen_t);

    mul_data_pkg::prod_t neg_prod;
    mul_data_pkg::prod_t signed_prod;
    mul_data_pkg::xlen_t word;

    // Negation as inverted product plus one.
    hc_adder u_neg (
        .a    (~exe.prod),
        .b    ('0),
        .cin  (1'b1),
        .sum  (neg_prod),
        .cout ()
    );

    assign signed_prod = exe.ctrl.negate ? neg_prod : exe.prod;
    assign word = exe.ctrl.take_high ? signed_prod[2*N-1:N] : signed_prod[N-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done      <= 1'b0;
            result    <= '0;
            result_rd <= '0;
        end else begin
            done      <= exe.ctrl.valid;
            result    <= word;
            result_rd <= exe.ctrl.rd;
        end
    end

endmodule

/* design/mul_unit.sv */
// RV32M multiply unit, three-stage pipeline with a fixed latency of three
// cycles from start to done and one request accepted per clock.
`timescale 1ns/1ps

module mul_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  mul_op_pkg::funct_t  funct,
    input  mul_data_pkg::xlen_t rs1,
    input  mul_data_pkg::xlen_t rs2,
    input  mul_data_pkg::rd_t   rd,
    output logic                done,
    output mul_data_pkg::xlen_t result,
    output mul_data_pkg::rd_t   result_rd
);

    mul_op_pkg::dec_out_t dec;
    mul_op_pkg::exe_out_t exe;

    mul_decode u_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .funct (funct),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd),
        .dec   (dec)
    );

    mul_execute u_execute (
        .clk   (clk),
        .rst_n (rst_n),
        .dec   (dec),
        .exe   (exe)
    );

    mul_result u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .exe       (exe),
        .done      (done),
        .result    (result),
        .result_rd (result_rd)
    );

endmodule

/* dv/mul_unit_tb.sv */
// Testbench for the RV32M multiply unit. Drives MUL, MULH, MULHSU and MULHU
// requests, compares every result against a reference model and checks latency.
`timescale 1ns/1ps

module mul_unit_tb;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 16;
    localparam int IDLE_CYCLES   = 20;
    localparam int LATENCY       = 3;
    localparam int DRAIN_CYCLES  = LATENCY + 2;
    localparam int NUM_CORNERS   = 6;
    localparam int RANDOM_PAIRS  = 200;
    localparam int B2B_REQS      = 300;
    localparam int MARGIN_CYCLES = 200;
    localparam int TOTAL_REQS    = 4 * (NUM_CORNERS * NUM_CORNERS + RANDOM_PAIRS) + B2B_REQS;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + IDLE_CYCLES + TOTAL_REQS + MARGIN_CYCLES;

    localparam mul_data_pkg::xlen_t CORNERS [NUM_CORNERS] = '{
        32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
        32'h8000_0000, 32'h7fff_ffff, 32'hffff_fffe
    };

    // One outstanding request as the comparator expects to see it.
    typedef struct packed {
        mul_data_pkg::xlen_t result;
        mul_data_pkg::rd_t   rd;
        int                  issue_cycle;
    } expect_t;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                start;
    mul_op_pkg::funct_t  funct;
    mul_data_pkg::xlen_t rs1;
    mul_data_pkg::xlen_t rs2;
    mul_data_pkg::rd_t   rd;
    logic                done;
    mul_data_pkg::xlen_t result;
    mul_data_pkg::rd_t   result_rd;

    expect_t expect_q [$];
    int      cycle = 0;
    int      checks = 0;
    int      errors = 0;
    int      test_count = 0;

    mul_unit dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .funct     (funct),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .done      (done),
        .result    (result),
        .result_rd (result_rd)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Sign-extends each operand as the operation reads it and keeps 64 bits.
    function automatic mul_data_pkg::xlen_t ref_mul(input mul_op_pkg::funct_t fn,
                                                    input mul_data_pkg::xlen_t a,
                                                    input mul_data_pkg::xlen_t b);
        logic        a_sgn;
        logic        b_sgn;
        logic [63:0] ext_a;
        logic [63:0] ext_b;
        logic [63:0] prod;
        a_sgn = (fn == mul_op_pkg::FN_MULH) || (fn == mul_op_pkg::FN_MULHSU);
        b_sgn = (fn == mul_op_pkg::FN_MULH);
        ext_a = {{32{a_sgn & a[31]}}, a};
        ext_b = {{32{b_sgn & b[31]}}, b};
        prod  = ext_a * ext_b;
        if (fn == mul_op_pkg::FN_MUL) begin
            return prod[31:0];
        end else begin
            return prod[63:32];
        end
    endfunction

    // The cycle counter advances on this same edge, so the start cycle is cycle + 1.
    task automatic issue_req(input mul_op_pkg::funct_t fn, input mul_data_pkg::xlen_t a,
                             input mul_data_pkg::xlen_t b, input mul_data_pkg::rd_t tag);
        expect_t item;
        @(posedge clk);
        start <= 1'b1;
        funct <= fn;
        rs1   <= a;
        rs2   <= b;
        rd    <= tag;
        item.result      = ref_mul(fn, a, b);
        item.rd          = tag;
        item.issue_cycle = cycle + 1;
        expect_q.push_back(item);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        start <= 1'b0;
        while (expect_q.size() != 0 && waited < DRAIN_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (expect_q.size() != 0) begin
            $display("ERROR: %0d requests never completed", expect_q.size());
            errors++;
            expect_q.delete();
        end
    endtask

    task automatic check_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            checks += 2;
            assert (done == 1'b0) else begin
                $display("MISMATCH done: got %h expected %h", done, 1'b0);
                errors++;
            end
            assert (result == '0) else begin
                $display("MISMATCH result: got %h expected %h", result, 32'h0);
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int checks_before,
                               input int errors_before);
        test_count++;
        $display("test %0d %s: %0d checks, %0d errors", test_count, name,
                 checks - checks_before, errors - errors_before);
    endtask

    // Corner pairs first, then random pairs, all with one operation code.
    task automatic run_op_test(input string name, input mul_op_pkg::funct_t fn);
        int c0;
        int e0;
        c0 = checks;
        e0 = errors;
        for (int i = 0; i < NUM_CORNERS; i++) begin
            for (int j = 0; j < NUM_CORNERS; j++) begin
                issue_req(fn, CORNERS[i], CORNERS[j], mul_data_pkg::rd_t'(i * NUM_CORNERS + j));
            end
        end
        for (int n = 0; n < RANDOM_PAIRS; n++) begin
            issue_req(fn, $urandom(), $urandom(), mul_data_pkg::rd_t'($urandom()));
        end
        drain();
        report_test(name, c0, e0);
    endtask

    always @(negedge clk) begin
        expect_t item;
        if (done === 1'b1) begin
            if (expect_q.size() == 0) begin
                $display("ERROR: done asserted at cycle %0d with no request outstanding", cycle);
                errors++;
            end else begin
                item = expect_q.pop_front();
                checks += 3;
                assert (result == item.result) else begin
                    $display("MISMATCH result: got %h expected %h", result, item.result);
                    errors++;
                end
                assert (result_rd == item.rd) else begin
                    $display("MISMATCH result_rd: got %h expected %h", result_rd, item.rd);
                    errors++;
                end
                assert (cycle - item.issue_cycle == LATENCY) else begin
                    $display("ERROR: done came %0d cycles after start instead of %0d",
                             cycle - item.issue_cycle, LATENCY);
                    errors++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired with %0d requests still outstanding",
                 expect_q.size());
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int c0;
        int e0;
        void'($urandom(32'h65ecc4dd));
        rst_n = 1'b0;
        start = 1'b0;
        funct = mul_op_pkg::FN_MUL;
        rs1   = '0;
        rs2   = '0;
        rd    = '0;

        c0 = checks;
        e0 = errors;
        check_idle(RESET_CYCLES - 1);
        @(posedge clk);
        rst_n <= 1'b1;
        check_idle(IDLE_CYCLES);
        report_test("reset and idle", c0, e0);

        run_op_test("MUL low word", mul_op_pkg::FN_MUL);
        run_op_test("MULHU high word", mul_op_pkg::FN_MULHU);
        run_op_test("MULH signed", mul_op_pkg::FN_MULH);
        run_op_test("MULHSU mixed", mul_op_pkg::FN_MULHSU);

        c0 = checks;
        e0 = errors;
        for (int n = 0; n < B2B_REQS; n++) begin
            issue_req(mul_op_pkg::funct_t'($urandom()), $urandom(), $urandom(),
                      mul_data_pkg::rd_t'($urandom()));
        end
        drain();
        report_test("back-to-back issue", c0, e0);

        $display("summary: %0d tests, %0d checks, %0d errors", test_count, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
design/mul_data_pkg.sv
design/mul_op_pkg.sv
design/hc_adder.sv
design/mul_decode.sv
design/mul_execute.sv
design/mul_result.sv
design/mul_unit.sv
dv/mul_unit_tb.sv

/* run.sh */
#!/bin/sh
# Builds the multiply unit testbench with Verilator, runs it and judges the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=mul_unit_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module mul_unit_tb -f vlog.f -o "$BIN"
if [ $? -ne 0 ]; then
    echo "run.sh: compile step failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "run.sh: simulation reported failures"
    exit 1
fi

if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
    echo "run.sh: simulation ended without a verdict"
    exit 1
fi

exit 0
